// ==== scrub_cfg_pkg.sv ====
/*
 * Scrub configuration package
 * Sizes of the DRAM scrub walk and the control/status register map
 */
`default_nettype none

package scrub_cfg_pkg;

   // Channel count and address width
   localparam int unsigned NUM_DDR     = 4;
   localparam int unsigned SCRB_ADDR_W = 64;

   // Simulation scrub size is 8 KiB per channel
   localparam logic [SCRB_ADDR_W-1:0] SCRB_MAX_ADDR    = 64'h1FFF;
   // 16 beats of 64 bytes per burst
   localparam logic [SCRB_ADDR_W-1:0] SCRB_BURST_BYTES = 64'd1024;
   localparam logic [SCRB_ADDR_W-1:0] SCRB_LAST_BURST  =
      SCRB_MAX_ADDR + 64'd1 - SCRB_BURST_BYTES;

   // ctl0 debug fields
   localparam int unsigned CTL_DBG_EN_BIT  = 31;
   localparam int unsigned CTL_DBG_SEL_LSB = 28;

   // Readback words
   localparam logic [31:0] CL_VERSION = 32'hEEEE_EE00;
   localparam logic [31:0] CL_ID0     = 32'hF000_1D0F;
   localparam logic [31:0] CL_ID1     = 32'h1D51_FEDD;

endpackage

`default_nettype wire

// ==== scrub_types_pkg.sv ====
/*
 * Scrub types package
 * Engine state encoding and fixed fields of the status word
 */
`default_nettype none

package scrub_types_pkg;

   //------------------------------
   // Engine state
   //------------------------------
   // Encoding is visible to software through the debug status word
   typedef enum logic [2:0] {
      SCRB_IDLE = 3'd0,
      SCRB_RUN  = 3'd1,
      SCRB_DONE = 3'd2
   } scrb_state_e;

   //------------------------------
   // Status word fields
   //------------------------------
   // Top of status0 in normal mode
   localparam logic [19:0] STAT_TAG  = 20'hA1111;
   // Constant nibble above the done bits
   localparam logic [3:0]  STAT_ONES = 4'hF;

endpackage

`default_nettype wire

// ==== scrb_if.sv ====
/*
 * Scrub engine link
 * Enable from the register block, state, address and done back from one engine
 */
`default_nettype none

interface scrb_if;
   import scrub_cfg_pkg::*;
   import scrub_types_pkg::*;

   logic                   enable;
   scrb_state_e            state;
   logic [SCRB_ADDR_W-1:0] addr;
   logic                   done;

   // Register block side
   modport ctl (
      output enable,
      input  state,
      input  addr,
      input  done
   );

   // Engine side
   modport engine (
      input  enable,
      output state,
      output addr,
      output done
   );

endinterface

`default_nettype wire

// ==== ddr_scrubber.sv ====
/*
 * DRAM scrub engine
 * Walks one channel from address 0 to the last burst, one burst per clock,
 * then parks in DONE until its enable drops
 */
`default_nettype none

module ddr_scrubber (
   input  logic     clk,
   input  logic     sync_rst_n,
   scrb_if.engine   scrb
);
   import scrub_cfg_pkg::*;
   import scrub_types_pkg::*;

   scrb_state_e            state;
   logic [SCRB_ADDR_W-1:0] addr;
   logic                   done;

   //------------------------------
   // Walk state machine
   //------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state <= SCRB_IDLE;
         addr  <= '0;
         done  <= 1'b0;
      end
      else if (!scrb.enable)
      begin
         // Dropping enable aborts the walk from any state
         state <= SCRB_IDLE;
         addr  <= '0;
         done  <= 1'b0;
      end
      else
      begin
         case (state)
            SCRB_IDLE:
            begin
               state <= SCRB_RUN;
               addr  <= '0;
            end
            SCRB_RUN:
            begin
               if (addr == SCRB_LAST_BURST)
               begin
                  // Address holds at the last burst
                  state <= SCRB_DONE;
                  done  <= 1'b1;
               end
               else
               begin
                  addr <= addr + SCRB_BURST_BYTES;
               end
            end
            SCRB_DONE:
            begin
               done <= 1'b1;
            end
            default:
            begin
               state <= SCRB_IDLE;
               addr  <= '0;
               done  <= 1'b0;
            end
         endcase
      end
   end

   assign scrb.state = state;
   assign scrb.addr  = addr;
   assign scrb.done  = done;

endmodule

`default_nettype wire

// ==== dram_scrub_csr.sv ====
/*
 * Scrub control and status registers
 * Captures ctl0 and DDR ready, drives engine enables, builds status and
 * debug ID readback, and answers function-level reset
 */
`default_nettype none

module dram_scrub_csr (
   input  logic                               clk,
   input  logic                               sync_rst_n,
   input  logic [31:0]                        ctl0,
   input  logic [scrub_cfg_pkg::NUM_DDR-1:0]  ddr_is_ready,
   input  logic                               flr_assert,
   output logic [31:0]                        status0,
   output logic [31:0]                        status1,
   output logic [31:0]                        id0,
   output logic [31:0]                        id1,
   output logic                               flr_done,
   scrb_if.ctl                                scrb_a,
   scrb_if.ctl                                scrb_b,
   scrb_if.ctl                                scrb_d,
   scrb_if.ctl                                scrb_c
);
   import scrub_cfg_pkg::*;
   import scrub_types_pkg::*;

   logic [31:0]            ctl0_q;
   logic [NUM_DDR-1:0]     ready_q;
   logic [NUM_DDR-1:0]     all_done;
   logic                   dbg_en;
   logic [2:0]             dbg_sel;
   logic [SCRB_ADDR_W-1:0] dbg_addr;
   logic                   flr_assert_q;

   //------------------------------
   // Control and ready capture
   //------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q  <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl0_q  <= ctl0;
         ready_q <= ddr_is_ready;
      end
   end

   // Enable bits 0..3 map to channels A, B, D, C
   assign scrb_a.enable = ctl0_q[0];
   assign scrb_b.enable = ctl0_q[1];
   assign scrb_d.enable = ctl0_q[2];
   assign scrb_c.enable = ctl0_q[3];

   assign dbg_en  = ctl0_q[CTL_DBG_EN_BIT];
   assign dbg_sel = ctl0_q[CTL_DBG_SEL_LSB +: 3];

   assign all_done = {scrb_c.done, scrb_d.done, scrb_b.done, scrb_a.done};

   //------------------------------
   // Status and ID readback
   //------------------------------
   always_ff @(posedge clk)
   begin
      if (dbg_en)
         status0 <= {1'b0, scrb_c.state, 1'b0, scrb_d.state,
                     1'b0, scrb_b.state, 1'b0, scrb_a.state,
                     4'h0, STAT_ONES, all_done, ready_q};
      else
         status0 <= {STAT_TAG, STAT_ONES, all_done, ready_q};
   end

   assign status1 = CL_VERSION;

   // Debug address select, unused codes fall back to channel A
   always_comb
   begin
      case (dbg_sel)
         3'd3:    dbg_addr = scrb_c.addr;
         3'd2:    dbg_addr = scrb_d.addr;
         3'd1:    dbg_addr = scrb_b.addr;
         default: dbg_addr = scrb_a.addr;
      endcase
   end

   always_ff @(posedge clk)
   begin
      id0 <= dbg_en ? dbg_addr[31:0]  : CL_ID0;
      id1 <= dbg_en ? dbg_addr[63:32] : CL_ID1;
   end

   //------------------------------
   // FLR response
   //------------------------------
   // Done pulses once per registered request, toggles if it is held
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

`default_nettype wire

// ==== dram_scrub_top.sv ====
/*
 * DRAM scrub top level
 * One register block steering four channel scrub engines (A, B, D, C)
 */
`default_nettype none

module dram_scrub_top (
   input  logic                               clk,
   input  logic                               sync_rst_n,
   input  logic [31:0]                        ctl0,
   input  logic [scrub_cfg_pkg::NUM_DDR-1:0]  ddr_is_ready,
   input  logic                               flr_assert,
   output logic [31:0]                        status0,
   output logic [31:0]                        status1,
   output logic [31:0]                        id0,
   output logic [31:0]                        id1,
   output logic                               flr_done
);

   // One link per channel
   scrb_if scrb_a ();
   scrb_if scrb_b ();
   scrb_if scrb_d ();
   scrb_if scrb_c ();

   dram_scrub_csr dram_scrub_csr_inst (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .status0      (status0),
      .status1      (status1),
      .id0          (id0),
      .id1          (id1),
      .flr_done     (flr_done),
      .scrb_a       (scrb_a.ctl),
      .scrb_b       (scrb_b.ctl),
      .scrb_d       (scrb_d.ctl),
      .scrb_c       (scrb_c.ctl)
   );

   //------------------------------
   // Channel engines
   //------------------------------
   ddr_scrubber ddr_scrubber_a_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb       (scrb_a.engine)
   );

   ddr_scrubber ddr_scrubber_b_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb       (scrb_b.engine)
   );

   ddr_scrubber ddr_scrubber_d_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb       (scrb_d.engine)
   );

   ddr_scrubber ddr_scrubber_c_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb       (scrb_c.engine)
   );

endmodule

`default_nettype wire

// ==== dram_scrub_properties.sv ====
/*
 * Scrub register block properties
 * Engine done and state agree, addresses stay in range, FLR done never stretches
 */
`default_nettype none

module dram_scrub_properties (
   input logic                                                          clk,
   input logic                                                          sync_rst_n,
   input logic [scrub_cfg_pkg::NUM_DDR-1:0]                             done_vec,
   input logic [3*scrub_cfg_pkg::NUM_DDR-1:0]                           state_vec,
   input logic [scrub_cfg_pkg::NUM_DDR*scrub_cfg_pkg::SCRB_ADDR_W-1:0]  addr_vec,
   input logic                                                          flr_done
);
   timeunit 1ns;
   timeprecision 1ps;
   import scrub_cfg_pkg::*;
   import scrub_types_pkg::*;

   //------------------------------
   // Per-channel engine checks
   //------------------------------
   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_chan
      done_in_done_state: assert property (@(posedge clk) disable iff (!sync_rst_n)
         done_vec[i] |-> state_vec[3*i +: 3] == SCRB_DONE)
         else $error("channel %0d raised done outside the DONE state", i);

      addr_in_range: assert property (@(posedge clk) disable iff (!sync_rst_n)
         addr_vec[SCRB_ADDR_W*i +: SCRB_ADDR_W] <= SCRB_LAST_BURST)
         else $error("channel %0d address ran past the last burst", i);
   end

   // A held request toggles done, so two high cycles in a row is a fault
   flr_done_single: assert property (@(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done)
      else $error("flr_done stayed high for two cycles");

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset held for a few cycles
 */
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic sync_rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release lands just after an edge, like the other stimulus
   initial
   begin
      sync_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 sync_rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== dram_scrub_tb.sv ====
/*
 * DRAM scrub testbench
 * Table of control words with expected status and ID readback, then FLR checks
 */
`default_nettype none

module dram_scrub_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import scrub_cfg_pkg::*;
   import scrub_types_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int NUM_ROWS     = 14;
   localparam int ROW_CYCLES   = 50;
   localparam int MIN_LATENCY  = 2;
   localparam int DONE_BOUND   = 20;
   localparam int SETTLE_BOUND = 8;
   localparam int FLR_BOUND    = 4;
   localparam int FLR_HOLD     = 6;
   localparam int FLR_WINDOW   = 6;
   // 8 KiB walk, final 1 KiB burst starts here
   localparam logic [31:0] LAST_BURST = 32'h2000 - 32'h400;

   typedef struct packed {
      logic [31:0] ctl0;
      logic        wait_done;
      logic [3:0]  ready;
      logic [31:0] status0;
      logic [31:0] id0;
      logic [31:0] id1;
   } row_t;

   logic        clk;
   logic        sync_rst_n;
   logic [31:0] ctl0;
   logic [3:0]  ddr_is_ready;
   logic        flr_assert;
   logic [31:0] status0;
   logic [31:0] status1;
   logic [31:0] id0;
   logic [31:0] id1;
   logic        flr_done;

   row_t        stim_rows [NUM_ROWS];
   logic [15:0] lfsr_state;
   int          error_count;
   int          tests_run;
   int          tests_failed;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) tb_clk_gen_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n)
   );

   dram_scrub_top dram_scrub_top_inst (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .status0      (status0),
      .status1      (status1),
      .id0          (id0),
      .id1          (id1),
      .flr_done     (flr_done)
   );

   bind dram_scrub_csr dram_scrub_properties dram_scrub_properties_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .done_vec   (all_done),
      .state_vec  ({scrb_c.state, scrb_d.state, scrb_b.state, scrb_a.state}),
      .addr_vec   ({scrb_c.addr, scrb_d.addr, scrb_b.addr, scrb_a.addr}),
      .flr_done   (flr_done)
   );

   //------------------------------
   // Stimulus and expected values
   //------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_ready(output logic [3:0] r);
      for (int i = 0; i < 4; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r[i] = lfsr_state[0];
      end
   endtask

   // An enabled channel has finished its walk by the time the row settles
   function automatic logic [2:0] exp_state(input logic en);
      return en ? SCRB_DONE : SCRB_IDLE;
   endfunction

   function automatic logic [31:0] exp_status0(input logic [31:0] ctl, input logic [3:0] rdy);
      if (ctl[31])
         return {1'b0, exp_state(ctl[3]), 1'b0, exp_state(ctl[2]),
                 1'b0, exp_state(ctl[1]), 1'b0, exp_state(ctl[0]),
                 4'h0, STAT_ONES, ctl[3:0], rdy};
      else
         return {STAT_TAG, STAT_ONES, ctl[3:0], rdy};
   endfunction

   // Select 0..3 lines up with enable bits A, B, D, C; higher codes read A
   function automatic logic [31:0] exp_id0(input logic [31:0] ctl);
      logic [2:0] sel;
      logic       chan_done;
      sel = ctl[30:28];
      chan_done = (sel <= 3'd3) ? ctl[sel] : ctl[0];
      if (!ctl[31])
         return CL_ID0;
      else
         return chan_done ? LAST_BURST : 32'h0;
   endfunction

   function automatic logic [31:0] exp_id1(input logic [31:0] ctl);
      return ctl[31] ? 32'h0 : CL_ID1;
   endfunction

   task automatic set_row(input int idx, input logic [31:0] ctl, input logic wait_done);
      logic [3:0] rdy;
      draw_ready(rdy);
      stim_rows[idx] = '{ctl0: ctl, wait_done: wait_done, ready: rdy,
                         status0: exp_status0(ctl, rdy), id0: exp_id0(ctl), id1: exp_id1(ctl)};
   endtask

   task automatic build_rows();
      set_row(0,  32'h0000_0000, 1'b0);
      set_row(1,  32'h0000_0000, 1'b0);
      set_row(2,  32'h0000_0000, 1'b0);
      set_row(3,  32'h0000_0001, 1'b1);
      set_row(4,  32'h8000_0001, 1'b0);
      set_row(5,  32'h9000_0001, 1'b0);
      set_row(6,  32'h9000_0003, 1'b1);
      set_row(7,  32'hB000_000F, 1'b1);
      set_row(8,  32'hA000_000F, 1'b0);
      set_row(9,  32'hF000_000F, 1'b0);
      set_row(10, 32'h8000_000E, 1'b0);
      set_row(11, 32'h0000_0000, 1'b0);
      set_row(12, 32'h0000_0004, 1'b1);
      set_row(13, 32'h0000_0008, 1'b1);
   endtask

   //------------------------------
   // Helpers
   //------------------------------
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
   endtask

   task automatic close_test(input string name, input int errors_before);
      tests_run++;
      if (error_count != errors_before)
      begin
         tests_failed++;
         $display("test %0d %s: failed", tests_run, name);
      end
      else
         $display("test %0d %s: passed", tests_run, name);
   endtask

   task automatic run_row(input int idx);
      row_t r;
      int   cycles;
      int   bound;
      int   errors_before;
      logic settled;
      r = stim_rows[idx];
      errors_before = error_count;
      bound = r.wait_done ? DONE_BOUND : SETTLE_BOUND;
      ctl0 = r.ctl0;
      ddr_is_ready = r.ready;
      cycles = 0;
      settled = 1'b0;
      // Capture then status register come before any readback can change
      while (!settled && cycles < bound)
      begin
         next_cycle();
         cycles++;
         settled = (cycles >= MIN_LATENCY) && (status0 === r.status0) &&
                   (id0 === r.id0) && (id1 === r.id1);
      end
      if (!settled)
      begin
         $display("readback for row %0d did not settle within %0d cycles", idx, bound);
         error_count++;
      end
      if (status0 !== r.status0)
         report_value("status0", status0, r.status0);
      if (status1 !== CL_VERSION)
         report_value("status1", status1, CL_VERSION);
      if (id0 !== r.id0)
         report_value("id0", id0, r.id0);
      if (id1 !== r.id1)
         report_value("id1", id1, r.id1);
      close_test($sformatf("row %0d ctl0=0x%08h ready=0x%h", idx, r.ctl0, r.ready),
                 errors_before);
   endtask

   //------------------------------
   // FLR checks
   //------------------------------
   task automatic check_flr_single();
      int cycles;
      int pulses;
      int errors_before;
      errors_before = error_count;
      flr_assert = 1'b1;
      next_cycle();
      flr_assert = 1'b0;
      cycles = 0;
      while (flr_done !== 1'b1 && cycles < FLR_BOUND)
      begin
         next_cycle();
         cycles++;
      end
      if (flr_done !== 1'b1)
      begin
         $display("flr_done never rose after a single-cycle flr_assert");
         error_count++;
      end
      pulses = 0;
      repeat (FLR_WINDOW)
      begin
         if (flr_done === 1'b1)
            pulses++;
         next_cycle();
      end
      if (pulses != 1)
         report_value("flr_done pulses", pulses, 1);
      close_test("single flr_assert", errors_before);
   endtask

   task automatic check_flr_held();
      int   pulses;
      int   back_to_back;
      int   errors_before;
      logic prev;
      errors_before = error_count;
      pulses = 0;
      back_to_back = 0;
      prev = 1'b0;
      flr_assert = 1'b1;
      for (int c = 0; c < FLR_HOLD + FLR_WINDOW; c++)
      begin
         if (c == FLR_HOLD)
            flr_assert = 1'b0;
         next_cycle();
         if (flr_done === 1'b1 && prev)
            back_to_back++;
         if (flr_done === 1'b1 && !prev)
            pulses++;
         prev = (flr_done === 1'b1);
      end
      if (pulses < 2)
      begin
         $display("held flr_assert gave %0d flr_done pulses, at least 2 expected", pulses);
         error_count++;
      end
      if (back_to_back != 0)
      begin
         $display("flr_done stayed high across %0d adjacent cycles", back_to_back);
         error_count++;
      end
      close_test("held flr_assert", errors_before);
   endtask

   //------------------------------
   // Main sequence and watchdog
   //------------------------------
   initial
   begin
      ctl0 = 32'h0;
      ddr_is_ready = 4'h0;
      flr_assert = 1'b0;
      lfsr_state = 16'd73;
      error_count = 0;
      tests_run = 0;
      tests_failed = 0;
      build_rows();
      @(posedge sync_rst_n);
      next_cycle();
      for (int i = 0; i < NUM_ROWS; i++)
         run_row(i);
      check_flr_single();
      check_flr_held();
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, error_count);
      if (error_count == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run stopped", NUM_ROWS * ROW_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
scrub_cfg_pkg.sv
scrub_types_pkg.sv
scrb_if.sv
ddr_scrubber.sv
dram_scrub_csr.sv
dram_scrub_top.sv
dram_scrub_properties.sv
tb_clk_gen.sv
dram_scrub_tb.sv

// ==== Makefile ====
# Verilator build and run of the DRAM scrub testbench

SRCS := $(filter-out +%,$(shell cat list.f))

.PHONY: all run clean

all: run

obj_dir/Vdram_scrub_tb: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dram_scrub_tb -f list.f -o Vdram_scrub_tb

# The log decides pass or fail
run: obj_dir/Vdram_scrub_tb
	./obj_dir/Vdram_scrub_tb > sim.log 2>&1 || true
	cat sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
